// File: common/mesh_defines.svh
// Mesh defaults for grid size, index width and payload width
`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

// Default grid size
`define MESH_ROWS    3
`define MESH_COLUMNS 3

// Width of one row or column index
// Must also hold the aggregator row index
`define MESH_ID_W    4

// Payload width, also one byte of the aggregated outputs
`define MESH_DATA_W  8

`endif

// File: common/mesh_pkg.sv
// Mesh package with port directions, opcodes and the message format
`include "mesh_defines.svh"

package mesh_pkg;

    // Port index used on every node port array
    typedef enum logic [1:0] {
        DIR_NORTH,
        DIR_SOUTH,
        DIR_EAST,
        DIR_WEST
    } mesh_dir_t;

    // Message operations
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_READ,
        OP_OUTPUT,
        OP_EGRESS
    } mesh_op_t;

    // Grid position, aggregators sit at row ROWS
    typedef struct packed {
        logic [`MESH_ID_W-1:0] row;
        logic [`MESH_ID_W-1:0] column;
    } node_id_t;

    // Message carried on every link
    typedef struct packed {
        node_id_t               target;
        mesh_op_t               op;
        logic [`MESH_DATA_W-1:0] data;
    } mesh_msg_t;

endpackage : mesh_pkg

// File: node/mesh_node.sv
// Mesh routing node with four ports, dimension-order routing and one data register
`include "mesh_defines.svh"

module mesh_node
import mesh_pkg::*;
#(
      parameter int ROWS    = `MESH_ROWS
    , parameter int COLUMNS = `MESH_COLUMNS
    , parameter int ROW_IDX = 0
    , parameter int COL_IDX = 0
) (
      input  logic            i_clk
    , input  logic            i_rst_n
    // Inbound ports, indexed by mesh_dir_t
    , input  mesh_msg_t [3:0] i_inbound_data
    , input  logic [3:0]      i_inbound_valid
    , output logic [3:0]      o_inbound_ready
    // Outbound ports, indexed by mesh_dir_t
    , output mesh_msg_t [3:0] o_outbound_data
    , output logic [3:0]      o_outbound_valid
    , input  logic [3:0]      i_outbound_ready
    // Idle chain from the node below
    , input  logic            i_idle
    , output logic            o_idle
);

// ============================
// Edge ports
// ============================

logic [3:0] in_present;
logic [3:0] out_present;

// Only node (0,0) takes the fabric stream on row 0
assign in_present[DIR_NORTH]  = (ROW_IDX > 0) || (COL_IDX == 0);
assign in_present[DIR_SOUTH]  = (ROW_IDX < ROWS - 1);
assign in_present[DIR_EAST]   = (COL_IDX < COLUMNS - 1);
assign in_present[DIR_WEST]   = (COL_IDX > 0);

// South always exists, bottom row feeds the aggregator
assign out_present[DIR_NORTH] = (ROW_IDX > 0);
assign out_present[DIR_SOUTH] = 1'b1;
assign out_present[DIR_EAST]  = (COL_IDX < COLUMNS - 1);
assign out_present[DIR_WEST]  = (COL_IDX > 0);

// ============================
// Route decode
// ============================

mesh_dir_t [3:0] route;
logic [3:0]      need_out;
logic [3:0]      is_load;
logic [3:0]      is_read;

always_comb begin
    for (int p = 0; p < 4; p++) begin
        route[p]    = DIR_SOUTH;
        need_out[p] = 1'b0;
        is_load[p]  = 1'b0;
        is_read[p]  = 1'b0;
        // Column first, then row
        if (i_inbound_data[p].target.column > COL_IDX) begin
            route[p]    = DIR_EAST;
            need_out[p] = out_present[DIR_EAST];
        end else if (i_inbound_data[p].target.column < COL_IDX) begin
            route[p]    = DIR_WEST;
            need_out[p] = out_present[DIR_WEST];
        end else if (i_inbound_data[p].target.row > ROW_IDX) begin
            need_out[p] = 1'b1;
        end else if (i_inbound_data[p].target.row == ROW_IDX) begin
            // Consumed here, READ needs the south register for its response
            is_load[p]  = (i_inbound_data[p].op == OP_LOAD);
            is_read[p]  = (i_inbound_data[p].op == OP_READ);
            need_out[p] = is_read[p];
        end
        // Routes toward an absent port fall through as drops
    end
end

// ============================
// Arbitration
// ============================

// Output registers and the data register
mesh_msg_t [3:0]        out_data_q;
logic [3:0]             out_valid_q;
logic [`MESH_DATA_W-1:0] data_q;

logic [3:0] out_free;
logic [3:0] request;
logic [3:0] grant;

// Free when empty or draining this cycle
assign out_free = ~out_valid_q | i_outbound_ready;

// Mask requests whose destination is busy
always_comb begin
    for (int p = 0; p < 4; p++) begin
        request[p] = i_inbound_valid[p] && in_present[p] &&
                     (!need_out[p] || out_free[route[p]]);
    end
end

node_arbiter #(
      .PORTS     ( 4       )
) u_arbiter (
      .i_clk     ( i_clk   )
    , .i_rst_n   ( i_rst_n )
    , .i_request ( request )
    , .o_grant   ( grant   )
);

// Ready in the same cycle as the grant
assign o_inbound_ready = grant;

// ============================
// Selected message
// ============================

mesh_msg_t sel_msg;
mesh_msg_t fwd_msg;
mesh_dir_t sel_route;
logic      sel_need;
logic      sel_load;
logic      sel_read;

always_comb begin
    sel_msg   = '0;
    sel_route = DIR_SOUTH;
    sel_need  = 1'b0;
    sel_load  = 1'b0;
    sel_read  = 1'b0;
    for (int p = 0; p < 4; p++) begin
        if (grant[p]) begin
            sel_msg   = i_inbound_data[p];
            sel_route = route[p];
            sel_need  = need_out[p];
            sel_load  = is_load[p];
            sel_read  = is_read[p];
        end
    end
end

// READ response heads for this column's aggregator
always_comb begin
    fwd_msg = sel_msg;
    if (sel_read) begin
        fwd_msg.target.row    = `MESH_ID_W'(ROWS);
        fwd_msg.target.column = `MESH_ID_W'(COL_IDX);
        fwd_msg.op            = OP_EGRESS;
        fwd_msg.data          = data_q;
    end
end

// ============================
// Registers
// ============================

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        out_valid_q <= '0;
        data_q      <= '0;
    end else begin
        // Drain on transfer, refill below wins on the same port
        out_valid_q <= out_valid_q & ~i_outbound_ready;
        if (sel_need) begin
            out_valid_q[sel_route] <= 1'b1;
        end
        if (sel_load) begin
            data_q <= sel_msg.data;
        end
    end
end

// Payload
always_ff @(posedge i_clk) begin
    if (sel_need) begin
        out_data_q[sel_route] <= fwd_msg;
    end
end

assign o_outbound_data  = out_data_q;
assign o_outbound_valid = out_valid_q & out_present;

// Idle when nothing is held here or below
assign o_idle = (out_valid_q == 4'd0) && i_idle;

endmodule : mesh_node

// File: node/node_arbiter.sv
// Round-robin arbiter granting one requester per cycle
module node_arbiter #(
      parameter int PORTS = 4
) (
      input  logic             i_clk
    , input  logic             i_rst_n
    , input  logic [PORTS-1:0] i_request
    , output logic [PORTS-1:0] o_grant
);

localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

// Index of the last granted port
logic [PTR_W-1:0] last_q;
logic [PTR_W-1:0] next_idx;
logic             found;

// ============================
// Grant selection
// ============================

// Search starts one past the last grant
always_comb begin
    int idx;
    o_grant  = '0;
    found    = 1'b0;
    next_idx = last_q;
    for (int off = 1; off <= PORTS; off++) begin
        idx = (int'(last_q) + off) % PORTS;
        if (!found && i_request[idx]) begin
            found        = 1'b1;
            o_grant[idx] = 1'b1;
            next_idx     = PTR_W'(idx);
        end
    end
end

// ============================
// Pointer update
// ============================

// Starts on the last port so port 0 wins first
// Pointer only moves when something was granted
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        last_q <= PTR_W'(PORTS - 1);
    end else if (found) begin
        last_q <= next_idx;
    end
end

endmodule : node_arbiter

// File: run_sim.sh
#!/bin/sh
# Build the mesh testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f sim.f --top-module mesh_tb \
    -Mdir "$BUILD_DIR" -o mesh_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mesh_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// File: sim.f
+incdir+common
common/mesh_pkg.sv
node/node_arbiter.sv
node/mesh_node.sv
verilog/mesh_aggregator.sv
verilog/mesh_fabric.sv
test/mesh_sva.sv
test/mesh_tb.sv

// File: test/mesh_sva.sv
// Protocol checker for the mesh fabric covering outbound hold, reset state and reset handshake
`include "mesh_defines.svh"

module mesh_sva
import mesh_pkg::*;
#(
      parameter int ROWS    = `MESH_ROWS
    , parameter int COLUMNS = `MESH_COLUMNS
) (
      input logic                                  i_clk
    , input logic                                  i_rst_n
    , input logic                                  i_inbound_valid
    , input logic                                  i_inbound_ready
    , input mesh_msg_t                             i_outbound_data
    , input logic                                  i_outbound_valid
    , input logic                                  i_outbound_ready
    , input logic [COLUMNS-1:0][`MESH_DATA_W-1:0] i_outputs
    , input logic [ROWS*COLUMNS*4-1:0]             i_node_valid
    , input logic [COLUMNS-1:0]                    i_agg_valid
);

timeunit 1ns;
timeprecision 1ps;

int unsigned hold_errors   = 0;
int unsigned reset_errors  = 0;
int unsigned accept_errors = 0;
int unsigned error_count;

assign error_count = hold_errors + reset_errors + accept_errors;

// ============================
// Properties
// ============================

// Stalled outbound keeps valid and data
a_outbound_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_outbound_valid && !i_outbound_ready |=> i_outbound_valid && $stable(i_outbound_data))
else begin
    hold_errors++;
    $error("outbound valid or data changed while ready was low");
end

// First cycle out of reset, every link quiet and bytes cleared
a_reset_state: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> (i_node_valid == '0) && (i_agg_valid == '0) &&
                       !i_outbound_valid && (i_outputs == '0))
else begin
    reset_errors++;
    $error("valid or output byte not cleared in the first cycle after reset");
end

// No inbound transfer during reset
a_no_reset_accept: assert property (@(posedge i_clk)
    !i_rst_n |-> !(i_inbound_valid && i_inbound_ready))
else begin
    accept_errors++;
    $error("inbound handshake completed while reset was asserted");
end

endmodule : mesh_sva

bind mesh_fabric mesh_sva #(
      .ROWS             ( ROWS             )
    , .COLUMNS          ( COLUMNS          )
) u_mesh_sva (
      .i_clk            ( i_clk            )
    , .i_rst_n          ( i_rst_n          )
    , .i_inbound_valid  ( i_inbound_valid  )
    , .i_inbound_ready  ( o_inbound_ready  )
    , .i_outbound_data  ( o_outbound_data  )
    , .i_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( i_outbound_ready )
    , .i_outputs        ( o_outputs        )
    , .i_node_valid     ( mesh_ob_valid    )
    , .i_agg_valid      ( agg_valid        )
);

// File: test/mesh_tb.sv
// Testbench for the mesh fabric, table-driven stimulus checked against a shadow model
`include "mesh_defines.svh"

module mesh_tb
import mesh_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int ROWS         = `MESH_ROWS;
localparam int COLUMNS      = `MESH_COLUMNS;
localparam int SEND_TIMEOUT = 200;
localparam int RESP_TIMEOUT = 200;
localparam int IDLE_TIMEOUT = 200;
localparam int STALL_CYCLES = 30;
localparam int MAX_BP_READS = 40;

typedef enum int {
    KIND_NONE,
    KIND_OUTPUT,
    KIND_EGRESS
} expect_kind_t;

// One table row
typedef struct {
    string                   name;
    mesh_op_t                op;
    int                      row;
    int                      column;
    logic [`MESH_DATA_W-1:0] data;
    expect_kind_t            kind;
} stim_entry_t;

logic                                 i_clk = 1'b0;
logic                                 i_rst_n;
mesh_msg_t                            i_inbound_data;
logic                                 i_inbound_valid;
logic                                 o_inbound_ready;
mesh_msg_t                            o_outbound_data;
logic                                 o_outbound_valid;
logic                                 i_outbound_ready;
logic [COLUMNS-1:0][`MESH_DATA_W-1:0] o_outputs;
logic [COLUMNS-1:0]                   o_node_idle;
logic                                 o_agg_idle;

stim_entry_t stim_table[$];
// Every outbound transfer in arrival order
mesh_msg_t   recv_q[$];
int          recv_base;

// Shadow model
logic [`MESH_DATA_W-1:0]              node_reg [ROWS][COLUMNS];
logic [COLUMNS-1:0][`MESH_DATA_W-1:0] out_bytes;

// 10 ns clock
always #5 i_clk = ~i_clk;

mesh_fabric #(
      .ROWS             ( ROWS             )
    , .COLUMNS          ( COLUMNS          )
) u_mesh_fabric (
      .i_clk            ( i_clk            )
    , .i_rst_n          ( i_rst_n          )
    , .i_inbound_data   ( i_inbound_data   )
    , .i_inbound_valid  ( i_inbound_valid  )
    , .o_inbound_ready  ( o_inbound_ready  )
    , .o_outbound_data  ( o_outbound_data  )
    , .o_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( i_outbound_ready )
    , .o_outputs        ( o_outputs        )
    , .o_node_idle      ( o_node_idle      )
    , .o_agg_idle       ( o_agg_idle       )
);

// Valid and ready seen at negedge means a transfer on the next edge
always @(negedge i_clk) begin
    if (i_rst_n && o_outbound_valid && i_outbound_ready) begin
        recv_q.push_back(o_outbound_data);
    end
end

// Bound checker tally
always @(negedge i_clk) begin
    assert (u_mesh_fabric.u_mesh_sva.error_count == 0)
        else report_failure("A protocol assertion on the fabric failed");
end

// ============================
// Helpers
// ============================

task automatic report_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual)
        else report_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h",
                                      name, expected, actual));
endtask

function automatic mesh_msg_t make_msg(input int row, input int column, input mesh_op_t op,
                                       input logic [`MESH_DATA_W-1:0] data);
    mesh_msg_t msg;
    msg.target.row    = `MESH_ID_W'(row);
    msg.target.column = `MESH_ID_W'(column);
    msg.op            = op;
    msg.data          = data;
    return msg;
endfunction

function automatic void add_entry(input string name, input mesh_op_t op, input int row,
                                  input int column, input logic [`MESH_DATA_W-1:0] data,
                                  input expect_kind_t kind);
    stim_entry_t entry;
    entry.name   = name;
    entry.op     = op;
    entry.row    = row;
    entry.column = column;
    entry.data   = data;
    entry.kind   = kind;
    stim_table.push_back(entry);
endfunction

task automatic build_table();
    logic [`MESH_DATA_W-1:0] loaded [ROWS][COLUMNS];
    // Output bytes, aggregators sit on row ROWS
    for (int c = 0; c < COLUMNS; c++) begin
        add_entry($sformatf("output_col%0d", c), OP_OUTPUT, ROWS, c,
                  `MESH_DATA_W'($urandom), KIND_OUTPUT);
    end
    // Load then read each node
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLUMNS; c++) begin
            loaded[r][c] = `MESH_DATA_W'($urandom);
            add_entry($sformatf("load_r%0dc%0d", r, c), OP_LOAD, r, c, loaded[r][c], KIND_NONE);
            add_entry($sformatf("read_r%0dc%0d", r, c), OP_READ, r, c, '0, KIND_EGRESS);
        end
    end
    // Overwrite the centre, then read everything back
    add_entry("overwrite_r1c1", OP_LOAD, 1, 1, ~loaded[1][1], KIND_NONE);
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLUMNS; c++) begin
            add_entry($sformatf("reread_r%0dc%0d", r, c), OP_READ, r, c, '0, KIND_EGRESS);
        end
    end
endtask

// Holds valid until ready or the limit runs out
task automatic wait_accept(input int limit, output bit accepted);
    int waited;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < limit) begin
        @(negedge i_clk);
        if (o_inbound_ready) begin
            accepted = 1'b1;
        end else begin
            waited++;
        end
    end
    if (accepted) begin
        @(posedge i_clk);
        i_inbound_valid <= 1'b0;
    end
endtask

task automatic send_msg(input string name, input mesh_msg_t msg);
    bit accepted;
    @(posedge i_clk);
    i_inbound_data  <= msg;
    i_inbound_valid <= 1'b1;
    wait_accept(SEND_TIMEOUT, accepted);
    assert (accepted)
        else report_failure($sformatf("%s: inbound message never accepted", name));
endtask

task automatic receive_response(input string name, output mesh_msg_t msg);
    int waited;
    waited = 0;
    while (recv_q.size() <= recv_base && waited < RESP_TIMEOUT) begin
        @(posedge i_clk);
        waited++;
    end
    assert (recv_q.size() > recv_base)
        else report_failure($sformatf("%s: no outbound response arrived", name));
    msg = recv_q[recv_base];
    recv_base++;
endtask

task automatic wait_output(input string name, input int column);
    int waited;
    waited = 0;
    while (o_outputs[column] !== out_bytes[column] && waited < IDLE_TIMEOUT) begin
        @(negedge i_clk);
        waited++;
    end
    assert (o_outputs[column] === out_bytes[column])
        else report_failure($sformatf("%s: output byte %0d never took its value", name, column));
endtask

// Registered idles lag, so skip a couple of cycles first
task automatic wait_idle(input string name);
    int  waited;
    bit  idle;
    waited = 0;
    idle   = 1'b0;
    repeat (2) @(negedge i_clk);
    while (!idle && waited < IDLE_TIMEOUT) begin
        @(negedge i_clk);
        idle = (o_node_idle == {COLUMNS{1'b1}}) && o_agg_idle;
        waited++;
    end
    assert (idle)
        else report_failure($sformatf("%s: mesh did not return to idle", name));
endtask

// ============================
// Main sequence
// ============================

initial begin
    stim_entry_t entry;
    mesh_msg_t   got;
    mesh_msg_t   exp_msg;
    mesh_msg_t   exp_q[$];
    mesh_msg_t   pool[$];
    bit          accepted;
    bit          stalled;
    bit          found;
    int          sent;
    int          row;
    int          col;
    int          bp_base;

    i_rst_n          = 1'b0;
    // Offered during reset, must stay unaccepted
    i_inbound_data   = make_msg(0, 0, OP_LOAD, 8'hA5);
    i_inbound_valid  = 1'b1;
    i_outbound_ready = 1'b1;
    recv_base        = 0;
    out_bytes        = '0;
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLUMNS; c++) begin
            node_reg[r][c] = '0;
        end
    end
    void'($urandom(30));
    build_table();

    // Reset for 10 cycles
    repeat (10) @(posedge i_clk);
    i_rst_n         <= 1'b1;
    i_inbound_valid <= 1'b0;
    @(negedge i_clk);
    check_value("reset_outputs", 32'd0, 32'(o_outputs));
    check_value("reset_outbound_valid", 32'd0, 32'(o_outbound_valid));
    check_value("reset_node_idle", 32'd0, 32'(o_node_idle));
    check_value("reset_agg_idle", 32'd0, 32'(o_agg_idle));
    wait_idle("reset_idle");

    // Table loop
    foreach (stim_table[i]) begin
        entry = stim_table[i];
        send_msg(entry.name, make_msg(entry.row, entry.column, entry.op, entry.data));
        if (entry.op == OP_LOAD) begin
            node_reg[entry.row][entry.column] = entry.data;
        end else if (entry.op == OP_OUTPUT) begin
            out_bytes[entry.column] = entry.data;
        end
        case (entry.kind)
            KIND_OUTPUT: begin
                wait_output(entry.name, entry.column);
                check_value(entry.name, 32'(out_bytes), 32'(o_outputs));
            end
            KIND_EGRESS: begin
                exp_msg = make_msg(ROWS, entry.column, OP_EGRESS,
                                   node_reg[entry.row][entry.column]);
                receive_response(entry.name, got);
                check_value(entry.name, 32'(exp_msg), 32'(got));
                // Exactly one response per READ
                wait_idle(entry.name);
                check_value({entry.name, "_count"}, 32'(recv_base), 32'(recv_q.size()));
            end
            default: begin
            end
        endcase
    end

    // Back-pressure, outbound blocked until the inbound stream stalls
    bp_base = recv_base;
    stalled = 1'b0;
    sent    = 0;
    row     = 0;
    col     = 0;
    @(posedge i_clk);
    i_outbound_ready <= 1'b0;
    while (!stalled && sent < MAX_BP_READS) begin
        row = (sent / COLUMNS) % ROWS;
        col = sent % COLUMNS;
        @(posedge i_clk);
        i_inbound_data  <= make_msg(row, col, OP_READ, '0);
        i_inbound_valid <= 1'b1;
        wait_accept(STALL_CYCLES, accepted);
        if (accepted) begin
            exp_q.push_back(make_msg(ROWS, col, OP_EGRESS, node_reg[row][col]));
            sent++;
        end else begin
            stalled = 1'b1;
        end
    end
    assert (stalled)
        else report_failure("Inbound stream did not stall with outbound ready held low");
    check_value("backpressure_valid", 32'd1, 32'(o_outbound_valid));

    // Release and finish the pending READ
    @(posedge i_clk);
    i_outbound_ready <= 1'b1;
    wait_accept(SEND_TIMEOUT, accepted);
    assert (accepted)
        else report_failure("backpressure: pending READ never accepted after release");
    exp_q.push_back(make_msg(ROWS, col, OP_EGRESS, node_reg[row][col]));

    wait_idle("idle_after_traffic");
    check_value("backpressure_count", 32'(exp_q.size()), 32'(recv_q.size() - bp_base));
    for (int i = bp_base; i < recv_q.size(); i++) begin
        pool.push_back(recv_q[i]);
    end
    // Order free match against the shadow
    while (exp_q.size() > 0) begin
        exp_msg = exp_q.pop_front();
        found   = 1'b0;
        for (int i = 0; i < pool.size(); i++) begin
            if (!found && pool[i] == exp_msg) begin
                pool.delete(i);
                found = 1'b1;
            end
        end
        assert (found)
            else report_failure($sformatf("Fail backpressure: expected 0x%0h, actual missing",
                                          exp_msg));
    end

    $display("Test passed");
    $finish;
end

endmodule : mesh_tb

// File: verilog/mesh_aggregator.sv
// Column aggregator driving one output byte and passing egress traffic west
`include "mesh_defines.svh"

module mesh_aggregator
import mesh_pkg::*;
#(
      parameter int COL_IDX = 0
) (
      input  logic                    i_clk
    , input  logic                    i_rst_n
    // From the bottom node of this column
    , input  mesh_msg_t               i_inbound_data
    , input  logic                    i_inbound_valid
    , output logic                    o_inbound_ready
    // From the aggregator to the east
    , input  mesh_msg_t               i_passthrough_data
    , input  logic                    i_passthrough_valid
    , output logic                    o_passthrough_ready
    // Toward column 0
    , output mesh_msg_t               o_outbound_data
    , output logic                    o_outbound_valid
    , input  logic                    i_outbound_ready
    // Output byte and idle
    , output logic [`MESH_DATA_W-1:0] o_output
    , output logic                    o_idle
);

// Port 0 is the mesh, port 1 the passthrough
mesh_msg_t [1:0] in_data;
logic [1:0]      in_valid;
logic [1:0]      is_output;
logic [1:0]      request;
logic [1:0]      grant;

mesh_msg_t               out_data_q;
logic                    out_valid_q;
logic [`MESH_DATA_W-1:0] output_q;
logic                    out_free;

mesh_msg_t sel_msg;
logic      sel_output;

assign in_data[0]  = i_inbound_data;
assign in_data[1]  = i_passthrough_data;
assign in_valid[0] = i_inbound_valid;
assign in_valid[1] = i_passthrough_valid;

assign out_free = !out_valid_q || i_outbound_ready;

// ============================
// Arbitration
// ============================

// OUTPUT for this column never needs the output register
always_comb begin
    for (int p = 0; p < 2; p++) begin
        is_output[p] = (in_data[p].op == OP_OUTPUT) &&
                       (in_data[p].target.column == COL_IDX);
        request[p]   = in_valid[p] && (is_output[p] || out_free);
    end
end

node_arbiter #(
      .PORTS     ( 2       )
) u_arbiter (
      .i_clk     ( i_clk   )
    , .i_rst_n   ( i_rst_n )
    , .i_request ( request )
    , .o_grant   ( grant   )
);

assign o_inbound_ready     = grant[0];
assign o_passthrough_ready = grant[1];

assign sel_msg    = grant[1] ? in_data[1] : in_data[0];
assign sel_output = |(grant & is_output);

// ============================
// Registers
// ============================

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        out_valid_q <= 1'b0;
        output_q    <= '0;
    end else begin
        if (i_outbound_ready) begin
            out_valid_q <= 1'b0;
        end
        if (|grant) begin
            if (sel_output) begin
                output_q <= sel_msg.data;
            end else begin
                out_valid_q <= 1'b1;
            end
        end
    end
end

// Forwarded message payload
always_ff @(posedge i_clk) begin
    if ((|grant) && !sel_output) begin
        out_data_q <= sel_msg;
    end
end

assign o_outbound_data  = out_data_q;
assign o_outbound_valid = out_valid_q;
assign o_output         = output_q;
assign o_idle           = !out_valid_q;

endmodule : mesh_aggregator

// File: verilog/mesh_fabric.sv
// Mesh top level building the node grid, the aggregator row and the idle outputs
`include "mesh_defines.svh"

module mesh_fabric
import mesh_pkg::*;
#(
      parameter int ROWS    = `MESH_ROWS
    , parameter int COLUMNS = `MESH_COLUMNS
) (
      input  logic                                  i_clk
    , input  logic                                  i_rst_n
    // Inbound stream into node (0,0)
    , input  mesh_msg_t                             i_inbound_data
    , input  logic                                  i_inbound_valid
    , output logic                                  o_inbound_ready
    // Outbound stream from aggregator 0
    , output mesh_msg_t                             o_outbound_data
    , output logic                                  o_outbound_valid
    , input  logic                                  i_outbound_ready
    // Aggregated output bytes
    , output logic [COLUMNS-1:0][`MESH_DATA_W-1:0] o_outputs
    // Idle status
    , output logic [COLUMNS-1:0]                    o_node_idle
    , output logic                                  o_agg_idle
);

// ============================
// Internal signals
// ============================

// Per-node port bundles, [row][column][direction]
mesh_msg_t [ROWS-1:0][COLUMNS-1:0][3:0] mesh_ob_data;
logic [ROWS-1:0][COLUMNS-1:0][3:0]      mesh_ob_valid;
logic [ROWS-1:0][COLUMNS-1:0][3:0]      mesh_ib_ready;
logic [ROWS-1:0][COLUMNS-1:0]           chain_idle;

// Aggregator chain
mesh_msg_t [COLUMNS-1:0] agg_data;
logic [COLUMNS-1:0]      agg_valid;
logic [COLUMNS-1:0]      agg_ready;
logic [COLUMNS-1:0]      agg_thru_ready;
logic [COLUMNS-1:0]      agg_ib_ready;
logic [COLUMNS-1:0]      agg_idle;

// Registered idles
logic [COLUMNS-1:0] column_idle_q;
logic               agg_idle_q;

// ============================
// Node grid
// ============================

for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    for (genvar c = 0; c < COLUMNS; c++) begin : gen_columns
        mesh_msg_t [3:0] node_ib_data;
        logic [3:0]      node_ib_valid;
        logic [3:0]      node_ob_ready;
        logic            node_in_idle;

        // North, fabric stream at (0,0) and nothing else on row 0
        if (r == 0) begin : gen_north_edge
            assign node_ib_data[DIR_NORTH]  = (c == 0) ? i_inbound_data : '0;
            assign node_ib_valid[DIR_NORTH] = (c == 0) ? i_inbound_valid : 1'b0;
            assign node_ob_ready[DIR_NORTH] = 1'b0;
        end else begin : gen_north_link
            assign node_ib_data[DIR_NORTH]  = mesh_ob_data[r-1][c][DIR_SOUTH];
            assign node_ib_valid[DIR_NORTH] = mesh_ob_valid[r-1][c][DIR_SOUTH];
            assign node_ob_ready[DIR_NORTH] = mesh_ib_ready[r-1][c][DIR_SOUTH];
        end

        // South, bottom row drains into the aggregator
        if (r == ROWS - 1) begin : gen_south_edge
            assign node_ib_data[DIR_SOUTH]  = '0;
            assign node_ib_valid[DIR_SOUTH] = 1'b0;
            assign node_ob_ready[DIR_SOUTH] = agg_ib_ready[c];
            assign node_in_idle             = 1'b1;
        end else begin : gen_south_link
            assign node_ib_data[DIR_SOUTH]  = mesh_ob_data[r+1][c][DIR_NORTH];
            assign node_ib_valid[DIR_SOUTH] = mesh_ob_valid[r+1][c][DIR_NORTH];
            assign node_ob_ready[DIR_SOUTH] = mesh_ib_ready[r+1][c][DIR_NORTH];
            assign node_in_idle             = chain_idle[r+1][c];
        end

        // East
        if (c == COLUMNS - 1) begin : gen_east_edge
            assign node_ib_data[DIR_EAST]  = '0;
            assign node_ib_valid[DIR_EAST] = 1'b0;
            assign node_ob_ready[DIR_EAST] = 1'b0;
        end else begin : gen_east_link
            assign node_ib_data[DIR_EAST]  = mesh_ob_data[r][c+1][DIR_WEST];
            assign node_ib_valid[DIR_EAST] = mesh_ob_valid[r][c+1][DIR_WEST];
            assign node_ob_ready[DIR_EAST] = mesh_ib_ready[r][c+1][DIR_WEST];
        end

        // West
        if (c == 0) begin : gen_west_edge
            assign node_ib_data[DIR_WEST]  = '0;
            assign node_ib_valid[DIR_WEST] = 1'b0;
            assign node_ob_ready[DIR_WEST] = 1'b0;
        end else begin : gen_west_link
            assign node_ib_data[DIR_WEST]  = mesh_ob_data[r][c-1][DIR_EAST];
            assign node_ib_valid[DIR_WEST] = mesh_ob_valid[r][c-1][DIR_EAST];
            assign node_ob_ready[DIR_WEST] = mesh_ib_ready[r][c-1][DIR_EAST];
        end

        mesh_node #(
              .ROWS             ( ROWS                )
            , .COLUMNS          ( COLUMNS             )
            , .ROW_IDX          ( r                   )
            , .COL_IDX          ( c                   )
        ) u_node (
              .i_clk            ( i_clk               )
            , .i_rst_n          ( i_rst_n             )
            , .i_inbound_data   ( node_ib_data        )
            , .i_inbound_valid  ( node_ib_valid       )
            , .o_inbound_ready  ( mesh_ib_ready[r][c] )
            , .o_outbound_data  ( mesh_ob_data[r][c]  )
            , .o_outbound_valid ( mesh_ob_valid[r][c] )
            , .i_outbound_ready ( node_ob_ready       )
            , .i_idle           ( node_in_idle        )
            , .o_idle           ( chain_idle[r][c]    )
        );
    end
end

// Nothing is taken from the stream while reset is held
assign o_inbound_ready = mesh_ib_ready[0][0][DIR_NORTH] && i_rst_n;

// ============================
// Aggregator row
// ============================

for (genvar c = 0; c < COLUMNS; c++) begin : gen_aggregators
    mesh_msg_t thru_data;
    logic      thru_valid;

    // Last column has no eastern neighbour
    if (c == COLUMNS - 1) begin : gen_thru_edge
        assign thru_data  = '0;
        assign thru_valid = 1'b0;
    end else begin : gen_thru_link
        assign thru_data  = agg_data[c+1];
        assign thru_valid = agg_valid[c+1];
    end

    // Column 0 feeds the outbound stream
    if (c == 0) begin : gen_ready_edge
        assign agg_ready[c] = i_outbound_ready;
    end else begin : gen_ready_link
        assign agg_ready[c] = agg_thru_ready[c-1];
    end

    mesh_aggregator #(
          .COL_IDX             ( c                                   )
    ) u_agg (
          .i_clk               ( i_clk                               )
        , .i_rst_n             ( i_rst_n                             )
        , .i_inbound_data      ( mesh_ob_data[ROWS-1][c][DIR_SOUTH]  )
        , .i_inbound_valid     ( mesh_ob_valid[ROWS-1][c][DIR_SOUTH] )
        , .o_inbound_ready     ( agg_ib_ready[c]                     )
        , .i_passthrough_data  ( thru_data                           )
        , .i_passthrough_valid ( thru_valid                          )
        , .o_passthrough_ready ( agg_thru_ready[c]                   )
        , .o_outbound_data     ( agg_data[c]                         )
        , .o_outbound_valid    ( agg_valid[c]                        )
        , .i_outbound_ready    ( agg_ready[c]                        )
        , .o_output            ( o_outputs[c]                        )
        , .o_idle              ( agg_idle[c]                         )
    );
end

assign o_outbound_data  = agg_data[0];
assign o_outbound_valid = agg_valid[0];

// ============================
// Idle outputs
// ============================

// Row 0 holds the whole column chain
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        column_idle_q <= '0;
        agg_idle_q    <= 1'b0;
    end else begin
        column_idle_q <= chain_idle[0];
        agg_idle_q    <= &agg_idle;
    end
end

assign o_node_idle = column_idle_q;
assign o_agg_idle  = agg_idle_q;

endmodule : mesh_fabric
